//--- hdl/glb_defs.svh
//==========================================================================
// Global buffer size macros
// Bank count and depth, data and address widths, port counts
//==========================================================================

`ifndef GLB_DEFS_SVH
`define GLB_DEFS_SVH

// Bank array
`define GLB_NUM_BANK      4
// Words per bank, must be a power of two
`define GLB_BANK_WORDS    16

// Datapath widths
`define GLB_DATA_W        32
`define GLB_ADDR_W        8

// Port counts
`define GLB_NUM_WRPORT    2
`define GLB_NUM_RDPORT    2

// Derived widths
`define GLB_OFFS_W        $clog2(`GLB_BANK_WORDS)
`define GLB_BANK_IDX_W    (`GLB_NUM_BANK > 1 ? $clog2(`GLB_NUM_BANK) : 1)

`endif

//--- hdl/glb_cfg_pkg.sv
//==========================================================================
// Global buffer configuration types
// Per-port bank ownership masks
//==========================================================================

`default_nettype none

`include "glb_defs.svh"

package glb_cfg_pkg;

    // One bit per bank, set when the port owns that bank
    typedef logic [`GLB_NUM_BANK-1:0] glb_bank_mask_t;

    // Full static configuration
    // Owned banks of one port are expected to be contiguous
    typedef struct packed {
        glb_bank_mask_t [`GLB_NUM_WRPORT-1:0] wr_mask;
        glb_bank_mask_t [`GLB_NUM_RDPORT-1:0] rd_mask;
    } glb_cfg_t;

endpackage

`default_nettype wire

//--- hdl/glb_port_pkg.sv
//==========================================================================
// Global buffer channel payloads
// Port write, port read-address, bank request and read-data structs
//==========================================================================

`default_nettype none

`include "glb_defs.svh"

package glb_port_pkg;

    // Write port beat
    typedef struct packed {
        logic [`GLB_ADDR_W-1:0] addr;
        logic [`GLB_DATA_W-1:0] data;
    } glb_wr_req_t;

    // Read-address beat
    typedef struct packed {
        logic [`GLB_ADDR_W-1:0] addr;
    } glb_rd_req_t;

    // Request as one bank sees it
    // data ignored for reads
    typedef struct packed {
        logic [`GLB_OFFS_W-1:0] word;
        logic [`GLB_DATA_W-1:0] data;
    } glb_bank_req_t;

    // Read-data beat
    typedef struct packed {
        logic [`GLB_DATA_W-1:0] data;
    } glb_rd_rsp_t;

endpackage

`default_nettype wire

//--- hdl/glb_prio_arb.sv
//==========================================================================
// Fixed-priority arbiter
// Lowest set request wins, returned as an index with a valid flag
//==========================================================================

`timescale 1ns/10ps
`default_nettype none

`include "glb_defs.svh"

module glb_prio_arb #(
    parameter int  NUM_REQ = 4,
    localparam int IDX_W   = (NUM_REQ > 1) ? $clog2(NUM_REQ) : 1
) (
    input  wire logic [NUM_REQ-1:0] req_i,
    output logic      [IDX_W-1:0]   idx_o,
    output logic                    any_o
);

    // Scan downwards so the lowest set bit is the last one written
    always_comb begin
        idx_o = '0;
        any_o = 1'b0;
        for (int i = NUM_REQ - 1; i >= 0; i--) begin
            if (req_i[i]) begin
                idx_o = IDX_W'(i);
                any_o = 1'b1;
            end
        end
    end

    // Index must name a live request
    always_comb begin
        a_idx_set : assert #0 (!any_o || req_i[idx_o])
            else $error("glb_prio_arb: idx %0d not requesting", idx_o);
    end

endmodule

`default_nettype wire

//--- hdl/glb_port_map.sv
//==========================================================================
// Port address to bank mapper
// Modulo reduction over owned banks, bank index and word offset split
//==========================================================================

`timescale 1ns/10ps
`default_nettype none

`include "glb_defs.svh"

module glb_port_map
    import glb_cfg_pkg::*;
#(
    parameter type payload_t = logic
) (
    input  wire logic                   clk_i,
    input  wire logic                   arst_n_i,
    input  wire glb_bank_mask_t         mask_i,
    input  wire logic [`GLB_ADDR_W-1:0] addr_i,
    input  wire payload_t               payload_i,
    input  wire logic                   valid_i,
    output glb_bank_mask_t              bank_hit_o,
    output logic [`GLB_OFFS_W-1:0]      word_o,
    output payload_t                    payload_o,
    output logic                        alloc_o
);

    localparam int OFFS_W  = `GLB_OFFS_W;
    localparam int IDX_W   = `GLB_BANK_IDX_W;
    localparam int CNT_W   = IDX_W + 1;
    localparam int SPACE_W = CNT_W + OFFS_W;

    logic [IDX_W-1:0]   first_idx;
    logic [CNT_W-1:0]   bank_cnt;
    logic [SPACE_W-1:0] space;
    logic [SPACE_W-1:0] addr_mod;
    logic [IDX_W-1:0]   bank_idx;

    // First owned bank, any_o doubles as the allocated flag
    glb_prio_arb #(
        .NUM_REQ (`GLB_NUM_BANK)
    ) u_first_bank (
        .req_i (mask_i),
        .idx_o (first_idx),
        .any_o (alloc_o)
    );

    // Owned bank count
    always_comb begin
        bank_cnt = '0;
        for (int b = 0; b < `GLB_NUM_BANK; b++) begin
            bank_cnt = bank_cnt + CNT_W'(mask_i[b]);
        end
    end

    // Linear space of the port, one bank when unowned to keep the divisor nonzero
    assign space    = alloc_o ? {bank_cnt, {OFFS_W{1'b0}}} : SPACE_W'(`GLB_BANK_WORDS);
    assign addr_mod = SPACE_W'(addr_i % space);

    // Upper bits pick the bank relative to the first owned one
    assign bank_idx = first_idx + IDX_W'(addr_mod[SPACE_W-1:OFFS_W]);
    assign word_o   = addr_mod[OFFS_W-1:0];

    // One-hot target, empty without a request or without ownership
    assign bank_hit_o = (valid_i && alloc_o) ? (glb_bank_mask_t'(1) << bank_idx) : '0;

    assign payload_o = payload_i;

    // Target bank stays inside the owned range
    a_hit_in_mask : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        valid_i |-> ($onehot0(bank_hit_o) && ((bank_hit_o & ~mask_i) == '0)))
        else $error("glb_port_map: hit %b outside mask %b", bank_hit_o, mask_i);

endmodule

`default_nettype wire

//--- hdl/glb_bank_ram.sv
//==========================================================================
// Single-port SRAM bank with valid/ready channels
// Write, read-address and read-data with a pending-data hold
//==========================================================================

`timescale 1ns/10ps
`default_nettype none

`include "glb_defs.svh"

module glb_bank_ram
    import glb_port_pkg::*;
(
    input  wire logic                   clk_i,
    input  wire logic                   arst_n_i,
    // Write channel
    input  wire logic                   wvalid_i,
    output logic                        wready_o,
    input  wire glb_bank_req_t          wreq_i,
    // Read-address channel
    input  wire logic                   arvalid_i,
    output logic                        arready_o,
    input  wire logic [`GLB_OFFS_W-1:0] araddr_i,
    // Read-data channel
    output logic                        rvalid_o,
    input  wire logic                   rready_i,
    output glb_rd_rsp_t                 rdata_o
);

    logic [`GLB_DATA_W-1:0] mem [`GLB_BANK_WORDS];
    glb_rd_rsp_t            rdata_q;
    logic                   rvalid_q;
    logic                   wr_fire;
    logic                   rd_fire;

    //======================================================================
    // Handshakes
    //======================================================================

    // Writes are never stalled
    assign wready_o = 1'b1;
    assign wr_fire  = wvalid_i & wready_o;

    // Single port, so a write takes the cycle
    // Held data also blocks the next address
    assign arready_o = ~(rvalid_q & ~rready_i) & ~wr_fire;
    assign rd_fire   = arvalid_i & arready_o;

    //======================================================================
    // Array and read register
    //======================================================================

    always_ff @(posedge clk_i) begin
        if (wr_fire) begin
            mem[wreq_i.word] <= wreq_i.data;
        end
    end

    // Loads only on an accepted address, so data holds while stalled
    always_ff @(posedge clk_i) begin
        if (rd_fire) begin
            rdata_q.data <= mem[araddr_i];
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rvalid_q <= 1'b0;
        end else if (rd_fire) begin
            rvalid_q <= 1'b1;
        end else if (rready_i) begin
            rvalid_q <= 1'b0;
        end
    end

    assign rvalid_o = rvalid_q;
    assign rdata_o  = rdata_q;

    // Read data is held until taken
    a_rvalid_hold : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o))
        else $error("glb_bank_ram: read data dropped without rready");

endmodule

`default_nettype wire

//--- hdl/glb_top.sv
//==========================================================================
// Global buffer top level
// Banks with owner arbiters, port mappers, read-return steering
// and per-port outstanding read tracking
//==========================================================================

`timescale 1ns/10ps
`default_nettype none

`include "glb_defs.svh"

module glb_top
    import glb_cfg_pkg::*;
    import glb_port_pkg::*;
(
    input  wire logic                                     clk_i,
    input  wire logic                                     arst_n_i,
    // Static while traffic runs
    input  wire glb_cfg_t                                 cfg_i,
    // Write channel
    input  wire glb_wr_req_t [`GLB_NUM_WRPORT-1:0]        wr_req_i,
    input  wire logic        [`GLB_NUM_WRPORT-1:0]        wr_valid_i,
    output logic             [`GLB_NUM_WRPORT-1:0]        wr_ready_o,
    // Read-address channel
    input  wire glb_rd_req_t [`GLB_NUM_RDPORT-1:0]        rd_req_i,
    input  wire logic        [`GLB_NUM_RDPORT-1:0]        rd_valid_i,
    output logic             [`GLB_NUM_RDPORT-1:0]        rd_ready_o,
    // Read-data channel
    output glb_rd_rsp_t      [`GLB_NUM_RDPORT-1:0]        rd_rsp_o,
    output logic             [`GLB_NUM_RDPORT-1:0]        rd_rsp_valid_o,
    input  wire logic        [`GLB_NUM_RDPORT-1:0]        rd_rsp_ready_i
);

    localparam int NB     = `GLB_NUM_BANK;
    localparam int NW     = `GLB_NUM_WRPORT;
    localparam int NR     = `GLB_NUM_RDPORT;
    localparam int OFFS_W = `GLB_OFFS_W;
    localparam int WP_W   = (NW > 1) ? $clog2(NW) : 1;
    localparam int RP_W   = (NR > 1) ? $clog2(NR) : 1;

    // Port side
    glb_bank_mask_t [NW-1:0]   wr_hit;
    logic [NW-1:0][OFFS_W-1:0] wr_word;
    glb_wr_req_t [NW-1:0]      wr_pay;
    logic [NW-1:0]             wr_alloc;
    glb_bank_mask_t [NW-1:0]   wr_gnt;
    glb_bank_mask_t [NR-1:0]   rd_hit;
    logic [NR-1:0][OFFS_W-1:0] rd_word;
    logic [NR-1:0]             rd_alloc;
    glb_bank_mask_t [NR-1:0]   rd_gnt;
    logic [NR-1:0]             rd_addr_fire;
    logic [NR-1:0]             rd_rsp_fire;
    // One read in flight per port, with its bank one-hot
    logic [NR-1:0]             rd_out_q;
    glb_bank_mask_t [NR-1:0]   rd_sel_q;

    // Bank side
    logic [NB-1:0][WP_W-1:0]   wr_own_idx;
    logic [NB-1:0]             wr_own_any;
    logic [NB-1:0][RP_W-1:0]   rd_own_idx;
    logic [NB-1:0]             rd_own_any;
    glb_bank_mask_t            bank_wready;
    glb_bank_mask_t            bank_arready;
    glb_bank_mask_t            bank_rvalid;
    glb_rd_rsp_t [NB-1:0]      bank_rdata;

    //======================================================================
    // Port mappers
    //======================================================================

    for (genvar p = 0; p < NW; p++) begin : g_wr_port
        glb_port_map #(
            .payload_t (glb_wr_req_t)
        ) u_map (
            .clk_i      (clk_i),
            .arst_n_i   (arst_n_i),
            .mask_i     (cfg_i.wr_mask[p]),
            .addr_i     (wr_req_i[p].addr),
            .payload_i  (wr_req_i[p]),
            .valid_i    (wr_valid_i[p]),
            .bank_hit_o (wr_hit[p]),
            .word_o     (wr_word[p]),
            .payload_o  (wr_pay[p]),
            .alloc_o    (wr_alloc[p])
        );

        // Ready only from a bank this port actually owns
        assign wr_ready_o[p] = wr_alloc[p] & |(wr_hit[p] & wr_gnt[p] & bank_wready);
    end

    for (genvar p = 0; p < NR; p++) begin : g_rd_port
        // address already split out, payload not needed downstream
        glb_port_map #(
            .payload_t (glb_rd_req_t)
        ) u_map (
            .clk_i      (clk_i),
            .arst_n_i   (arst_n_i),
            .mask_i     (cfg_i.rd_mask[p]),
            .addr_i     (rd_req_i[p].addr),
            .payload_i  (rd_req_i[p]),
            .valid_i    (rd_valid_i[p]),
            .bank_hit_o (rd_hit[p]),
            .word_o     (rd_word[p]),
            .payload_o  (),
            .alloc_o    (rd_alloc[p])
        );

        assign rd_ready_o[p] = rd_alloc[p] & ~rd_out_q[p]
                             & |(rd_hit[p] & rd_gnt[p] & bank_arready);
        assign rd_rsp_valid_o[p] = rd_out_q[p] & |(rd_sel_q[p] & bank_rvalid);

        // Returned data holds across back-pressure
        a_rsp_hold : assert property (@(posedge clk_i) disable iff (!arst_n_i)
            rd_rsp_valid_o[p] && !rd_rsp_ready_i[p]
            |=> rd_rsp_valid_o[p] && $stable(rd_rsp_o[p]))
            else $error("glb_top: read port %0d data changed while stalled", p);
    end

    assign rd_addr_fire = rd_valid_i & rd_ready_o;
    assign rd_rsp_fire  = rd_rsp_valid_o & rd_rsp_ready_i;

    // Port to bank grants from the owner arbiters
    always_comb begin
        for (int b = 0; b < NB; b++) begin
            for (int p = 0; p < NW; p++) begin
                wr_gnt[p][b] = wr_own_any[b] && (wr_own_idx[b] == WP_W'(p));
            end
            for (int p = 0; p < NR; p++) begin
                rd_gnt[p][b] = rd_own_any[b] && (rd_own_idx[b] == RP_W'(p));
            end
        end
    end

    //======================================================================
    // Banks and owner arbitration
    //======================================================================

    for (genvar b = 0; b < NB; b++) begin : g_bank
        logic [NW-1:0]     wr_claim;
        logic [NR-1:0]     rd_claim;
        glb_bank_req_t     wreq;
        logic              wvalid;
        logic              arvalid;
        logic [OFFS_W-1:0] araddr;
        logic              rready;

        // Ports claiming this bank
        always_comb begin
            for (int p = 0; p < NW; p++) begin
                wr_claim[p] = cfg_i.wr_mask[p][b];
            end
            for (int p = 0; p < NR; p++) begin
                rd_claim[p] = cfg_i.rd_mask[p][b];
            end
        end

        glb_prio_arb #(
            .NUM_REQ (NW)
        ) u_wr_arb (
            .req_i (wr_claim),
            .idx_o (wr_own_idx[b]),
            .any_o (wr_own_any[b])
        );

        glb_prio_arb #(
            .NUM_REQ (NR)
        ) u_rd_arb (
            .req_i (rd_claim),
            .idx_o (rd_own_idx[b]),
            .any_o (rd_own_any[b])
        );

        // Owner's mapper drives the bank
        assign wvalid    = wr_own_any[b] & wr_hit[wr_own_idx[b]][b];
        assign wreq.word = wr_word[wr_own_idx[b]];
        assign wreq.data = wr_pay[wr_own_idx[b]].data;

        // Gated by outstanding so bank and port handshakes coincide
        assign arvalid = rd_own_any[b] & rd_hit[rd_own_idx[b]][b] & ~rd_out_q[rd_own_idx[b]];
        assign araddr  = rd_word[rd_own_idx[b]];
        assign rready  = rd_rsp_ready_i[rd_own_idx[b]];

        glb_bank_ram u_ram (
            .clk_i     (clk_i),
            .arst_n_i  (arst_n_i),
            .wvalid_i  (wvalid),
            .wready_o  (bank_wready[b]),
            .wreq_i    (wreq),
            .arvalid_i (arvalid),
            .arready_o (bank_arready[b]),
            .araddr_i  (araddr),
            .rvalid_o  (bank_rvalid[b]),
            .rready_i  (rready),
            .rdata_o   (bank_rdata[b])
        );
    end

    //======================================================================
    // Read return steering
    //======================================================================

    // Outstanding flag and bank latched at the address handshake
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_out_q <= '0;
            rd_sel_q <= '0;
        end else begin
            for (int p = 0; p < NR; p++) begin
                if (rd_addr_fire[p]) begin
                    rd_out_q[p] <= 1'b1;
                    rd_sel_q[p] <= rd_hit[p];
                end else if (rd_rsp_fire[p]) begin
                    rd_out_q[p] <= 1'b0;
                end
            end
        end
    end

    // Data from the latched bank
    always_comb begin
        for (int p = 0; p < NR; p++) begin
            rd_rsp_o[p] = '0;
            for (int b = 0; b < NB; b++) begin
                if (rd_sel_q[p][b]) begin
                    rd_rsp_o[p] = bank_rdata[b];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/glb_tb.sv
//==========================================================================
// Global buffer testbench
// Step table with a physical reference memory, watchdog, error count
//==========================================================================

`timescale 1ns/10ps
`default_nettype none

`include "glb_defs.svh"

module glb_tb
    import glb_cfg_pkg::*;
    import glb_port_pkg::*;
();

    typedef enum logic [1:0] {OP_WR, OP_RD, OP_RD_STALL} op_e;

    // One table row
    typedef struct packed {
        glb_cfg_t               cfg;
        op_e                    op;
        logic                   port;
        logic [`GLB_ADDR_W-1:0] addr;
        logic [`GLB_DATA_W-1:0] data;
        logic                   ready_exp;
    } step_t;

    logic                                clk_i;
    logic                                arst_n_i;
    glb_cfg_t                            cfg_i;
    glb_wr_req_t [`GLB_NUM_WRPORT-1:0]   wr_req_i;
    logic        [`GLB_NUM_WRPORT-1:0]   wr_valid_i;
    logic        [`GLB_NUM_WRPORT-1:0]   wr_ready_o;
    glb_rd_req_t [`GLB_NUM_RDPORT-1:0]   rd_req_i;
    logic        [`GLB_NUM_RDPORT-1:0]   rd_valid_i;
    logic        [`GLB_NUM_RDPORT-1:0]   rd_ready_o;
    glb_rd_rsp_t [`GLB_NUM_RDPORT-1:0]   rd_rsp_o;
    logic        [`GLB_NUM_RDPORT-1:0]   rd_rsp_valid_o;
    logic        [`GLB_NUM_RDPORT-1:0]   rd_rsp_ready_i;

    step_t                  steps [$];
    string                  step_name [$];
    // Physical contents, bank then word
    logic [`GLB_DATA_W-1:0] ref_mem [`GLB_NUM_BANK][`GLB_BANK_WORDS];
    int                     num_steps = 0;
    int                     checks = 0;
    int                     errors = 0;

    glb_top dut (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .cfg_i          (cfg_i),
        .wr_req_i       (wr_req_i),
        .wr_valid_i     (wr_valid_i),
        .wr_ready_o     (wr_ready_o),
        .rd_req_i       (rd_req_i),
        .rd_valid_i     (rd_valid_i),
        .rd_ready_o     (rd_ready_o),
        .rd_rsp_o       (rd_rsp_o),
        .rd_rsp_valid_o (rd_rsp_valid_o),
        .rd_rsp_ready_i (rd_rsp_ready_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    //======================================================================
    // Helpers
    //======================================================================

    task automatic check_value(input string name, input logic [`GLB_DATA_W-1:0] exp,
                               input logic [`GLB_DATA_W-1:0] act);
        checks++;
        assert (act === exp) else begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    function automatic glb_cfg_t make_cfg(input glb_bank_mask_t wr0, input glb_bank_mask_t wr1,
                                          input glb_bank_mask_t rd0, input glb_bank_mask_t rd1);
        glb_cfg_t c;
        c.wr_mask[0] = wr0;
        c.wr_mask[1] = wr1;
        c.rd_mask[0] = rd0;
        c.rd_mask[1] = rd1;
        return c;
    endfunction

    // Owned banks form one space, address taken modulo its size
    function automatic void map_addr(input glb_bank_mask_t mask, input logic [7:0] addr,
                                     output int bank, output int word);
        int n;
        int first;
        int a;
        n     = 0;
        first = -1;
        for (int b = 0; b < `GLB_NUM_BANK; b++) begin
            if (mask[b]) begin
                n++;
                if (first < 0) first = b;
            end
        end
        a    = int'(addr) % (n * `GLB_BANK_WORDS);
        bank = first + a / `GLB_BANK_WORDS;
        word = a % `GLB_BANK_WORDS;
    endfunction

    task automatic add_step(input string name, input glb_cfg_t cfg, input op_e op,
                            input int port, input logic [7:0] addr, input logic ready_exp);
        step_t s;
        s.cfg       = cfg;
        s.op        = op;
        s.port      = port[0];
        s.addr      = addr;
        s.data      = $urandom;
        s.ready_exp = ready_exp;
        steps.push_back(s);
        step_name.push_back(name);
    endtask

    task automatic build_table();
        glb_cfg_t c;
        glb_cfg_t c_split;
        // Single bank round trip
        c = make_cfg(4'b0001, 4'b0000, 4'b0001, 4'b0000);
        add_step("single_bank_wr", c, OP_WR, 0, 8'h05, 1'b1);
        add_step("single_bank_rd", c, OP_RD, 0, 8'h05, 1'b1);
        // Upper half of two banks, read back through the second bank alone
        c = make_cfg(4'b0110, 4'b0000, 4'b0110, 4'b0100);
        // Port 0 reads only the lower bank so port 1 owns the upper one
        c_split = make_cfg(4'b0110, 4'b0000, 4'b0010, 4'b0100);
        add_step("two_bank_wr", c, OP_WR, 0, 8'h13, 1'b1);
        add_step("two_bank_rd_owner", c, OP_RD, 0, 8'h13, 1'b1);
        add_step("two_bank_rd_other", c_split, OP_RD, 1, 8'h03, 1'b1);
        // Wrap modulo 32 owned words
        add_step("wrap_wr", c, OP_WR, 0, 8'h07, 1'b1);
        add_step("wrap_rd", c, OP_RD, 0, 8'h47, 1'b1);
        add_step("wrap_wr_high", c, OP_WR, 0, 8'hE5, 1'b1);
        add_step("wrap_rd_low", c, OP_RD, 0, 8'h05, 1'b1);
        // Port 1 owns nothing
        c = make_cfg(4'b0001, 4'b0000, 4'b0001, 4'b0000);
        add_step("empty_mask_wr", c, OP_WR, 1, 8'h02, 1'b0);
        add_step("empty_mask_rd", c, OP_RD, 1, 8'h02, 1'b0);
        // Back-pressure on read data
        c = make_cfg(4'b1000, 4'b0000, 4'b1000, 4'b0000);
        add_step("stall_wr", c, OP_WR, 0, 8'h0A, 1'b1);
        add_step("stall_rd", c, OP_RD_STALL, 0, 8'h0A, 1'b1);
        // Shared bank, port 0 wins
        c = make_cfg(4'b0100, 4'b0100, 4'b0100, 4'b0000);
        add_step("shared_wr_p0", c, OP_WR, 0, 8'h04, 1'b1);
        add_step("shared_wr_p1", c, OP_WR, 1, 8'h04, 1'b0);
        add_step("shared_rd", c, OP_RD, 0, 8'h04, 1'b1);
    endtask

    //======================================================================
    // Channel drivers
    //======================================================================

    task automatic run_write(input string name, input step_t s);
        int p;
        int bank;
        int word;
        p = int'(s.port);
        @(negedge clk_i);
        cfg_i            = s.cfg;
        wr_req_i[p].addr = s.addr;
        wr_req_i[p].data = s.data;
        wr_valid_i[p]    = 1'b1;
        if (s.ready_exp) begin
            do @(posedge clk_i); while (!wr_ready_o[p]);
            map_addr(s.cfg.wr_mask[p], s.addr, bank, word);
            ref_mem[bank][word] = s.data;
        end else begin
            repeat (4) begin
                @(posedge clk_i);
                check_value(name, '0, wr_ready_o[p]);
            end
        end
        @(negedge clk_i);
        wr_valid_i[p] = 1'b0;
    endtask

    task automatic run_read(input string name, input step_t s, input logic stall);
        int                     p;
        int                     bank;
        int                     word;
        logic [`GLB_DATA_W-1:0] exp;
        p = int'(s.port);
        @(negedge clk_i);
        cfg_i            = s.cfg;
        rd_req_i[p].addr = s.addr;
        rd_valid_i[p]    = 1'b1;
        if (!s.ready_exp) begin
            repeat (4) begin
                @(posedge clk_i);
                check_value(name, '0, rd_ready_o[p]);
                check_value(name, '0, rd_rsp_valid_o[p]);
            end
            @(negedge clk_i);
            rd_valid_i[p] = 1'b0;
        end else begin
            map_addr(s.cfg.rd_mask[p], s.addr, bank, word);
            exp = ref_mem[bank][word];
            if (stall) rd_rsp_ready_i[p] = 1'b0;
            do @(posedge clk_i); while (!rd_ready_o[p]);
            if (stall) begin
                // Valid stays up as the next address
                repeat (4) begin
                    @(posedge clk_i);
                    check_value(name, 1'b1, rd_rsp_valid_o[p]);
                    check_value(name, exp, rd_rsp_o[p].data);
                    check_value(name, '0, rd_ready_o[p]);
                end
                @(negedge clk_i);
                rd_rsp_ready_i[p] = 1'b1;
                // Data taken here, next address only after it
                @(posedge clk_i);
                check_value(name, '0, rd_ready_o[p]);
                do @(posedge clk_i); while (!rd_ready_o[p]);
            end
            @(negedge clk_i);
            rd_valid_i[p] = 1'b0;
            do @(posedge clk_i); while (!rd_rsp_valid_o[p]);
            check_value(name, exp, rd_rsp_o[p].data);
        end
    endtask

    //======================================================================
    // Main sequence and watchdog
    //======================================================================

    initial begin
        void'($urandom(89));
        arst_n_i       = 1'b0;
        cfg_i          = '0;
        wr_req_i       = '0;
        wr_valid_i     = '0;
        rd_req_i       = '0;
        rd_valid_i     = '0;
        rd_rsp_ready_i = '1;
        build_table();
        num_steps = steps.size();
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        arst_n_i = 1'b1;
        for (int i = 0; i < num_steps; i++) begin
            case (steps[i].op)
                OP_WR:   run_write(step_name[i], steps[i]);
                OP_RD:   run_read(step_name[i], steps[i], 1'b0);
                default: run_read(step_name[i], steps[i], 1'b1);
            endcase
        end
        repeat (2) @(negedge clk_i);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Budget of 20 cycles per step plus reset
    initial begin
        wait (num_steps > 0);
        repeat ((num_steps + 1) * 20) @(posedge clk_i);
        $display("Timeout: the step table did not finish within %0d cycles",
                 (num_steps + 1) * 20);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+hdl
hdl/glb_cfg_pkg.sv
hdl/glb_port_pkg.sv
hdl/glb_prio_arb.sv
hdl/glb_port_map.sv
hdl/glb_bank_ram.sv
hdl/glb_top.sv
verif/glb_tb.sv

//--- Bender.yml
package:
  name: glb

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/glb_cfg_pkg.sv
      - hdl/glb_port_pkg.sv
      - hdl/glb_prio_arb.sv
      - hdl/glb_port_map.sv
      - hdl/glb_bank_ram.sv
      - hdl/glb_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/glb_tb.sv
